// ==== rtl/nes_bus_pkg.sv ====
// Bus widths and SDRAM region layout shared by the mapper RTL
// Pulled in by scoped names in port lists and a wildcard import in bodies
`default_nettype none

package nes_bus_pkg;

	// CPU side
	localparam int CPU_AW = 16;         // 6502 address bus
	localparam int DATA_W = 8;          // CPU data bus

	// PPU side
	localparam int PPU_AW = 14;         // Pattern plus nametable space

	// SDRAM side
	localparam int MEM_AW = 22;         // 4 MB of cartridge memory

	// PRG ROM starts at address zero
	// CHR data lives in the upper half of SDRAM
	localparam int CHR_REGION_BIT = 21; // Set for every CHR access

	// CPU address as seen by the cartridge slot
	typedef logic [CPU_AW-1:0] cpu_addr_t;

	// PPU address as seen by the cartridge slot
	typedef logic [PPU_AW-1:0] ppu_addr_t;

	// Mapped SDRAM address
	typedef logic [MEM_AW-1:0] mem_addr_t;

	// CPU write data
	typedef logic [DATA_W-1:0] data_t;

endpackage

`default_nettype wire

// ==== rtl/mapper_pkg.sv ====
// Board numbers and bank layout constants for the discrete-logic mappers
// Shared by register decode and the PRG and CHR address mapping blocks
`default_nettype none

package mapper_pkg;

	// iNES mapper numbers handled by this controller
	typedef enum logic [7:0] {
		MAP_NROM         = 8'd0,   // No registers
		MAP_COLOR_DREAMS = 8'd11,  // 32K PRG plus 8K CHR
		MAP_BXROM        = 8'd34,  // 32K PRG only
		MAP_GXROM        = 8'd66,  // 32K PRG plus 8K CHR
		MAP_CAMERICA     = 8'd71,  // 16K switchable plus fixed last
		MAP_CAMERICA_232 = 8'd232  // Camerica with outer bank
	} mapper_e;

	// Bank placement in the PRG address
	localparam int PRG32_SHIFT = 15;          // 32 KB window

	localparam int PRG16_SHIFT = 14;          // 16 KB window

	// Bank placement in the CHR address
	localparam int CHR8_SHIFT  = 13;          // 8 KB pattern bank

	// Camerica fixed upper bank
	// The $C000 window always sees the last 16 KB of PRG ROM
	localparam logic [3:0] LAST16_BANK = 4'b1111;

endpackage

`default_nettype wire

// ==== rtl/bank_regs.sv ====
// Bank and mirroring registers for the discrete boards
// Decodes CPU writes into the ROM window per board and latches on ce
`timescale 1ns/1ps
`default_nettype none

module bank_regs #(
	parameter int PRG_BANK_W = 6,               // PRG bank register width
	parameter int CHR_BANK_W = 4                // CHR bank register width
) (
	input  logic                   clk,
	input  logic                   rst_n,         // Async clear of all banks
	input  logic                   ce,            // One cycle per CPU bus access
	input  mapper_pkg::mapper_e    mapper_id,     // Stable between resets
	input  nes_bus_pkg::cpu_addr_t prg_ain,       // Used for write decode only
	input  logic                   prg_write,
	input  nes_bus_pkg::data_t     prg_din,
	output logic [PRG_BANK_W-1:0]  prg_bank,      // Inner PRG bank
	output logic [CHR_BANK_W-1:0]  chr_bank,      // 8K CHR bank
	output logic [1:0]             outer_bank,    // #232 outer 64K block
	output logic                   ciram_select   // Fire Hawk one-screen page
);
	import mapper_pkg::*;

	logic                  wr_stb;             // Qualified write strobe
	logic                  in_rom;             // $8000-$FFFF
	logic                  in_lo_half;         // $8000-$BFFF
	logic                  in_hi_half;         // $C000-$FFFF
	logic                  in_first8k;         // $8000-$9FFF
	logic                  prg_ld;
	logic                  chr_ld;
	logic                  outer_ld;
	logic                  ciram_ld;
	logic [PRG_BANK_W-1:0] prg_nxt;
	logic [CHR_BANK_W-1:0] chr_nxt;

	assign wr_stb     = ce & prg_write;
	assign in_rom     = prg_ain[15];
	assign in_lo_half = (prg_ain[15:14] == 2'b10);
	assign in_hi_half = (prg_ain[15:14] == 2'b11);
	assign in_first8k = (prg_ain[15:13] == 3'b100);

	// Per-board window and data layout
	always_comb begin
		prg_ld   = 1'b0;
		chr_ld   = 1'b0;
		outer_ld = 1'b0;
		ciram_ld = 1'b0;
		prg_nxt  = '0;
		chr_nxt  = '0;
		case (mapper_id)
			MAP_COLOR_DREAMS: begin
				prg_ld  = in_rom;
				chr_ld  = in_rom;
				prg_nxt = PRG_BANK_W'(prg_din[1:0]);  // PRG in low bits
				chr_nxt = CHR_BANK_W'(prg_din[7:4]);  // CHR in high nibble
			end
			MAP_GXROM: begin
				prg_ld  = in_rom;
				chr_ld  = in_rom;
				prg_nxt = PRG_BANK_W'(prg_din[5:4]);  // Swapped vs Color Dreams
				chr_nxt = CHR_BANK_W'(prg_din[1:0]);
			end
			MAP_BXROM: begin
				prg_ld  = in_rom;                     // CHR stays at bank 0
				prg_nxt = PRG_BANK_W'(prg_din[5:0]);  // Oversize 6-bit bank
			end
			MAP_CAMERICA: begin
				prg_ld   = in_hi_half;                // Bank select at $C000
				ciram_ld = in_first8k;                // Fire Hawk mirroring at $8000
				prg_nxt  = PRG_BANK_W'(prg_din[3:0]);
			end
			MAP_CAMERICA_232: begin
				prg_ld   = in_hi_half;                // Inner bank at $C000
				outer_ld = in_lo_half;                // Outer bank at $8000
				prg_nxt  = PRG_BANK_W'(prg_din[1:0]);
			end
			default: ;                                // NROM has no registers
		endcase
	end

	// Registers take the decoded value on a qualified strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prg_bank     <= '0;
			chr_bank     <= '0;
			outer_bank   <= 2'b00;
			ciram_select <= 1'b0;
		end else if (wr_stb) begin
			if (prg_ld)
				prg_bank <= prg_nxt;
			if (chr_ld)
				chr_bank <= chr_nxt;
			if (outer_ld)
				outer_bank <= prg_din[4:3];          // 64K block select
			if (ciram_ld)
				ciram_select <= prg_din[4];          // One-screen page
		end
	end

endmodule

`default_nettype wire

// ==== rtl/prg_map.sv ====
// CPU address to PRG ROM address translation
// Picks 32K or 16K banking per board, combinational from prg_ain
`timescale 1ns/1ps
`default_nettype none

module prg_map #(
	parameter int PRG_BANK_W = 6                  // PRG bank register width
) (
	input  mapper_pkg::mapper_e    mapper_id,
	input  nes_bus_pkg::cpu_addr_t prg_ain,       // CPU address
	input  logic                   prg_write,
	input  logic [PRG_BANK_W-1:0]  prg_bank,      // From bank_regs
	input  logic [1:0]             outer_bank,    // #232 only
	output nes_bus_pkg::mem_addr_t prg_aout,      // PRG ROM address
	output logic                   prg_allow      // ROM read grant
);
	import nes_bus_pkg::*;
	import mapper_pkg::*;

	logic [3:0] bank16;                 // 16K bank for Camerica boards
	mem_addr_t  addr32;                 // 32K banked address
	mem_addr_t  addr16;                 // 16K banked address
	mem_addr_t  addr_nrom;              // Straight 32K

	// Camerica upper half is pinned to a fixed bank
	always_comb begin
		if (mapper_id == MAP_CAMERICA_232) begin
			if (prg_ain[14])
				bank16 = {outer_bank, 2'b11};         // Last bank of the outer block
			else
				bank16 = {outer_bank, prg_bank[1:0]};
		end else begin
			if (prg_ain[14])
				bank16 = LAST16_BANK;                 // Fixed last 16K
			else
				bank16 = prg_bank[3:0];
		end
	end

	assign addr32    = (mem_addr_t'(prg_bank) << PRG32_SHIFT)
	                 | mem_addr_t'(prg_ain[14:0]);
	assign addr16    = (mem_addr_t'(bank16) << PRG16_SHIFT)
	                 | mem_addr_t'(prg_ain[13:0]);
	assign addr_nrom = mem_addr_t'(prg_ain[14:0]);  // PRG ROM sits at zero

	// Board select
	always_comb begin
		case (mapper_id)
			MAP_COLOR_DREAMS,
			MAP_GXROM,
			MAP_BXROM:        prg_aout = addr32;
			MAP_CAMERICA,
			MAP_CAMERICA_232: prg_aout = addr16;
			default:          prg_aout = addr_nrom; // NROM
		endcase
	end

	// Reads only, upper 32K only
	assign prg_allow = prg_ain[15] & ~prg_write;

endmodule

`default_nettype wire

// ==== rtl/chr_map.sv ====
// PPU address to CHR address and nametable routing
// Pattern fetches go to SDRAM and nametable fetches to CIRAM
`timescale 1ns/1ps
`default_nettype none

module chr_map #(
	parameter int CHR_BANK_W = 4                  // CHR bank register width
) (
	input  mapper_pkg::mapper_e    mapper_id,
	input  nes_bus_pkg::ppu_addr_t chr_ain,       // PPU address
	input  logic [CHR_BANK_W-1:0]  chr_bank,      // From bank_regs
	input  logic                   ciram_select,  // Fire Hawk page
	input  logic                   mirror_vertical, // Header mirroring bit
	input  logic                   chr_ram,       // CHR is writable RAM
	output nes_bus_pkg::mem_addr_t chr_aout,      // CHR SDRAM address
	output logic                   chr_allow,     // CHR write grant
	output logic                   vram_a10,      // CIRAM A10
	output logic                   vram_ce        // Route to CIRAM
);
	import nes_bus_pkg::*;
	import mapper_pkg::*;

	mem_addr_t chr_offs;                // Bank plus offset in bank
	logic      one_screen;              // Fire Hawk single page mode

	assign chr_offs = (mem_addr_t'(chr_bank) << CHR8_SHIFT)
	                | mem_addr_t'(chr_ain[12:0]);
	assign chr_aout = (mem_addr_t'(1) << CHR_REGION_BIT) | chr_offs; // Into the CHR region

	assign chr_allow = chr_ram;          // Writes only land in CHR RAM
	assign vram_ce   = chr_ain[13];      // $2000-$3FFF is nametable space

	// Fire Hawk carts ship with horizontal in the header
	assign one_screen = (mapper_id == MAP_CAMERICA) & ~mirror_vertical;

	always_comb begin
		if (mirror_vertical)
			vram_a10 = chr_ain[10];           // Vertical mirroring
		else if (one_screen)
			vram_a10 = ciram_select;          // Register picks the page
		else
			vram_a10 = chr_ain[11];           // Horizontal mirroring
	end

endmodule

`default_nettype wire

// ==== rtl/discrete_mapper.sv ====
// Top level of the discrete-logic cartridge controller
// Connects register decode to the PRG and CHR/nametable address maps
`timescale 1ns/1ps
`default_nettype none

module discrete_mapper #(
	parameter int PRG_BANK_W = 6,               // BxROM needs all 6 bits
	parameter int CHR_BANK_W = 4                // Color Dreams CHR nibble
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   ce,              // CPU bus cycle strobe
	input  mapper_pkg::mapper_e    mapper_id,       // Change only in reset
	input  logic                   mirror_vertical, // Header bit
	input  logic                   chr_ram,         // CHR is RAM
	input  nes_bus_pkg::cpu_addr_t prg_ain,
	input  logic                   prg_write,
	input  nes_bus_pkg::data_t     prg_din,
	input  nes_bus_pkg::ppu_addr_t chr_ain,
	output nes_bus_pkg::mem_addr_t prg_aout,
	output logic                   prg_allow,
	output nes_bus_pkg::mem_addr_t chr_aout,
	output logic                   chr_allow,
	output logic                   vram_a10,
	output logic                   vram_ce
);

	logic [PRG_BANK_W-1:0] prg_bank;            // Inner PRG bank
	logic [CHR_BANK_W-1:0] chr_bank;            // 8K CHR bank
	logic [1:0]            outer_bank;          // #232 outer block
	logic                  ciram_select;        // One-screen page

	// Write decode and bank state
	bank_regs #(
		.PRG_BANK_W (PRG_BANK_W),
		.CHR_BANK_W (CHR_BANK_W)
	) u_bank_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.ce           (ce),
		.mapper_id    (mapper_id),
		.prg_ain      (prg_ain),
		.prg_write    (prg_write),
		.prg_din      (prg_din),
		.prg_bank     (prg_bank),
		.chr_bank     (chr_bank),
		.outer_bank   (outer_bank),
		.ciram_select (ciram_select)
	);

	// CPU side mapping
	prg_map #(
		.PRG_BANK_W (PRG_BANK_W)
	) u_prg_map (
		.mapper_id  (mapper_id),
		.prg_ain    (prg_ain),
		.prg_write  (prg_write),
		.prg_bank   (prg_bank),
		.outer_bank (outer_bank),
		.prg_aout   (prg_aout),
		.prg_allow  (prg_allow)
	);

	// PPU side mapping
	chr_map #(
		.CHR_BANK_W (CHR_BANK_W)
	) u_chr_map (
		.mapper_id       (mapper_id),
		.chr_ain         (chr_ain),
		.chr_bank        (chr_bank),
		.ciram_select    (ciram_select),
		.mirror_vertical (mirror_vertical),
		.chr_ram         (chr_ram),
		.chr_aout        (chr_aout),
		.chr_allow       (chr_allow),
		.vram_a10        (vram_a10),
		.vram_ce         (vram_ce)
	);

endmodule

`default_nettype wire

// ==== verif/discrete_mapper_chk.sv ====
// Concurrent checks on the mapper outputs, bound into discrete_mapper
// Sampled on the rising clock outside reset
`timescale 1ns/1ps
`default_nettype none

module discrete_mapper_chk (
	input logic                   clk,
	input logic                   rst_n,
	input nes_bus_pkg::cpu_addr_t prg_ain,
	input logic                   prg_write,
	input logic                   prg_allow,
	input nes_bus_pkg::ppu_addr_t chr_ain,
	input nes_bus_pkg::mem_addr_t chr_aout,
	input logic                   vram_ce
);
	import nes_bus_pkg::*;

	int fail_cnt = 0;                  // Failed assertion count

	// ROM grant only for reads in the upper 32K
	a_allow_read: assert property (@(posedge clk) disable iff (!rst_n)
		prg_allow |-> (prg_ain[15] && !prg_write))
		else begin
			fail_cnt++;
			$error("prg_allow high outside a ROM read");
		end

	// Nametable space is PPU A13
	a_vram_ce: assert property (@(posedge clk) disable iff (!rst_n)
		vram_ce == chr_ain[13])
		else begin
			fail_cnt++;
			$error("vram_ce does not follow chr_ain[13]");
		end

	a_chr_region: assert property (@(posedge clk) disable iff (!rst_n)
		chr_aout[CHR_REGION_BIT])
		else begin
			fail_cnt++;
			$error("chr_aout outside the CHR region");
		end

endmodule

bind discrete_mapper discrete_mapper_chk u_chk (
	.clk       (clk),
	.rst_n     (rst_n),
	.prg_ain   (prg_ain),
	.prg_write (prg_write),
	.prg_allow (prg_allow),
	.chr_ain   (chr_ain),
	.chr_aout  (chr_aout),
	.vram_ce   (vram_ce)
);

`default_nettype wire

// ==== verif/map_scoreboard.sv ====
// Scoreboard for the discrete mapper: shadow bank registers and expected outputs
// Compares on the falling edge, then applies the write seen in that cycle
`timescale 1ns/1ps
`default_nettype none

module map_scoreboard (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   ce,
	input  mapper_pkg::mapper_e    mapper_id,
	input  logic                   mirror_vertical,
	input  logic                   chr_ram,
	input  nes_bus_pkg::cpu_addr_t prg_ain,
	input  logic                   prg_write,
	input  nes_bus_pkg::data_t     prg_din,
	input  nes_bus_pkg::ppu_addr_t chr_ain,
	input  nes_bus_pkg::mem_addr_t prg_aout,
	input  logic                   prg_allow,
	input  nes_bus_pkg::mem_addr_t chr_aout,
	input  logic                   chr_allow,
	input  logic                   vram_a10,
	input  logic                   vram_ce,
	output int                     checks,
	output int                     mismatches
);
	import nes_bus_pkg::*;
	import mapper_pkg::*;

	logic [5:0] sh_prg   = '0;         // Shadow inner PRG bank
	logic [3:0] sh_chr   = '0;         // Shadow CHR bank
	logic [1:0] sh_outer = '0;         // Shadow #232 outer bank
	logic       sh_page  = 1'b0;       // Shadow Fire Hawk page
	int         n_checks = 0;
	int         n_bad    = 0;

	assign checks     = n_checks;
	assign mismatches = n_bad;

	// Expected PRG address, counted in 16K pages
	function automatic mem_addr_t ref_prg_addr(input mapper_e m, input cpu_addr_t a,
			input logic [5:0] bank, input logic [1:0] outer);
		int unsigned page;
		int unsigned hi;
		hi = 32'(a[14]);
		case (m)
			MAP_COLOR_DREAMS, MAP_GXROM, MAP_BXROM: page = 32'(bank) * 2 + hi;
			MAP_CAMERICA:     page = a[14] ? 15 : 32'(bank[3:0]);   // Last page fixed
			MAP_CAMERICA_232: page = 32'(outer) * 4 + (a[14] ? 3 : 32'(bank[1:0]));
			default:          page = hi;                            // Flat 32K
		endcase
		return mem_addr_t'(page * 16384 + 32'(a[13:0]));
	endfunction

	function automatic mem_addr_t ref_chr_addr(input logic [3:0] bank, input ppu_addr_t a);
		return mem_addr_t'((32'd1 << CHR_REGION_BIT) + 32'(bank) * 8192 + 32'(a[12:0]));
	endfunction

	function automatic logic ref_a10(input mapper_e m, input logic vert, input ppu_addr_t a,
			input logic page);
		if (vert)
			return a[10];
		if (m == MAP_CAMERICA)
			return page;                   // One-screen page
		return a[11];
	endfunction

	task automatic expect_val(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			n_bad = n_bad + 1;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	always @(negedge clk) begin
		if (!rst_n) begin
			sh_prg   = '0;
			sh_chr   = '0;
			sh_outer = '0;
			sh_page  = 1'b0;
		end
		n_checks = n_checks + 1;
		expect_val("prg_aout", 32'(prg_aout), 32'(ref_prg_addr(mapper_id, prg_ain, sh_prg, sh_outer)));
		expect_val("prg_allow", 32'(prg_allow), 32'(prg_ain >= 16'h8000 && !prg_write));
		expect_val("chr_aout", 32'(chr_aout), 32'(ref_chr_addr(sh_chr, chr_ain)));
		expect_val("chr_allow", 32'(chr_allow), 32'(chr_ram));
		expect_val("vram_ce", 32'(vram_ce), 32'(chr_ain >= 14'h2000));
		expect_val("vram_a10", 32'(vram_a10),
			32'(ref_a10(mapper_id, mirror_vertical, chr_ain, sh_page)));
		// Write lands on the next rising edge
		if (rst_n && ce && prg_write) begin
			case (mapper_id)
				MAP_COLOR_DREAMS: if (prg_ain >= 16'h8000) begin
					sh_prg = {4'b0000, prg_din[1:0]};
					sh_chr = prg_din[7:4];
				end
				MAP_GXROM: if (prg_ain >= 16'h8000) begin
					sh_prg = {4'b0000, prg_din[5:4]};
					sh_chr = {2'b00, prg_din[1:0]};
				end
				MAP_BXROM: if (prg_ain >= 16'h8000)
					sh_prg = prg_din[5:0];
				MAP_CAMERICA: begin
					if (prg_ain >= 16'hC000)
						sh_prg = {2'b00, prg_din[3:0]};
					if (prg_ain >= 16'h8000 && prg_ain <= 16'h9FFF)
						sh_page = prg_din[4];
				end
				MAP_CAMERICA_232: begin
					if (prg_ain >= 16'hC000)
						sh_prg = {4'b0000, prg_din[1:0]};
					else if (prg_ain >= 16'h8000)
						sh_outer = prg_din[4:3];
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_discrete_mapper.sv ====
// Testbench for the discrete mapper: LFSR bus traffic per board, one line per test
// Top of the Verilator run; map_scoreboard does the comparing
`timescale 1ns/1ps
`default_nettype none

module tb_discrete_mapper;
	import nes_bus_pkg::*;
	import mapper_pkg::*;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        ce;
	mapper_e     mapper_id;
	logic        mirror_vertical;
	logic        chr_ram;
	cpu_addr_t   prg_ain;
	logic        prg_write;
	data_t       prg_din;
	ppu_addr_t   chr_ain;
	mem_addr_t   prg_aout;
	logic        prg_allow;
	mem_addr_t   chr_aout;
	logic        chr_allow;
	logic        vram_a10;
	logic        vram_ce;
	int          checks;                // Scoreboard cycle count
	int          mismatches;            // Scoreboard error count
	logic [15:0] lfsr_state;
	logic        timed_out;
	int          tests_ok;
	int          tests_bad;
	int          base_checks;
	int          base_mism;

	always #10 clk = ~clk;              // 20 ns period

	discrete_mapper u_discrete_mapper (.*);

	map_scoreboard u_scoreboard (.*);

	// Galois LFSR, x^16+x^14+x^13+x^11+1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		return s >> 1;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// Kind 0 read, 1..4 write to a window, 5 anything
	task automatic bus_cycle(input int kind, input logic ce_val);
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] p;
		logic [31:0] w;
		logic [15:0] addr;
		take_bits(16, a);
		take_bits(8, d);
		take_bits(14, p);
		take_bits(2, w);
		case (kind)
			1:       addr = {1'b1, a[14:0]};     // $8000-$FFFF
			2:       addr = {3'b100, a[12:0]};   // $8000-$9FFF
			3:       addr = {3'b101, a[12:0]};   // $A000-$BFFF
			4:       addr = {2'b11, a[13:0]};    // $C000-$FFFF
			default: addr = a[15:0];
		endcase
		@(posedge clk);
		ce        <= ce_val;
		prg_ain   <= addr;
		prg_write <= (kind == 5) ? w[0] : (kind != 0);
		prg_din   <= d[7:0];
		chr_ain   <= p[13:0];
		chr_ram   <= w[1];
	endtask

	task automatic run_mix(input int n, input int k1, input int k2, input int k3,
			input logic ce_val);
		logic [31:0] sel;
		for (int i = 0; i < n; i++) begin
			take_bits(2, sel);
			case (sel[1:0])
				2'd1:    bus_cycle(k1, ce_val);
				2'd2:    bus_cycle(k2, ce_val);
				2'd3:    bus_cycle(k3, ce_val);
				default: bus_cycle(0, ce_val);
			endcase
		end
	endtask

	// Board and header bit only change inside reset
	task automatic apply_reset(input mapper_e m, input logic mv);
		int n;
		@(posedge clk);
		rst_n           <= 1'b0;
		ce              <= 1'b0;
		prg_write       <= 1'b0;
		mapper_id       <= m;
		mirror_vertical <= mv;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		n = 0;
		while (rst_n !== 1'b1 && !timed_out) begin
			@(posedge clk);
			n++;
			if (n > 4) begin
				$display("timeout: reset release was not seen within 4 cycles");
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic finish_test(input string name);
		int target;
		int n;
		target = checks + 1;             // Last driven cycle compared
		n = 0;
		while (checks < target && !timed_out) begin
			@(posedge clk);
			n++;
			if (n > 20) begin
				$display("timeout: scoreboard stopped comparing during %s", name);
				timed_out = 1'b1;
			end
		end
		if (timed_out || mismatches != base_mism)
			tests_bad++;
		else
			tests_ok++;
		$display("%s: %0d cycles, %0d mismatches, %s", name, checks - base_checks,
			mismatches - base_mism, (timed_out || mismatches != base_mism) ? "bad" : "ok");
		base_checks = checks;
		base_mism   = mismatches;
	endtask

	initial begin
		rst_n = 1'b0;
		ce = 1'b0;
		mapper_id = MAP_NROM;
		mirror_vertical = 1'b0;
		chr_ram = 1'b0;
		prg_ain = '0;
		prg_write = 1'b0;
		prg_din = '0;
		chr_ain = '0;
		lfsr_state = 16'd10;
		timed_out = 1'b0;
		tests_ok = 0;
		tests_bad = 0;
		base_checks = 0;
		base_mism = 0;
		apply_reset(MAP_NROM, 1'b1);
		run_mix(48, 5, 5, 5, 1'b1);
		finish_test("nrom");
		apply_reset(MAP_COLOR_DREAMS, 1'b0);
		run_mix(48, 1, 1, 0, 1'b1);
		finish_test("color_dreams");
		apply_reset(MAP_GXROM, 1'b1);
		run_mix(48, 1, 1, 0, 1'b1);
		finish_test("gxrom");
		apply_reset(MAP_BXROM, 1'b1);
		run_mix(48, 1, 1, 0, 1'b1);
		finish_test("bxrom");
		apply_reset(MAP_CAMERICA, 1'b0);   // Fire Hawk one-screen
		run_mix(64, 4, 2, 3, 1'b1);
		apply_reset(MAP_CAMERICA, 1'b1);
		run_mix(32, 4, 2, 0, 1'b1);
		finish_test("camerica_71");
		apply_reset(MAP_CAMERICA_232, 1'b0);
		run_mix(64, 2, 3, 4, 1'b1);
		finish_test("camerica_232");
		apply_reset(MAP_GXROM, 1'b0);
		run_mix(8, 1, 1, 1, 1'b1);
		run_mix(32, 1, 1, 5, 1'b0);        // Writes without ce
		finish_test("ce_low");
		apply_reset(MAP_COLOR_DREAMS, 1'b1);
		run_mix(16, 1, 1, 1, 1'b1);
		apply_reset(MAP_COLOR_DREAMS, 1'b0);
		run_mix(16, 0, 0, 0, 1'b1);        // Banks back at 0
		apply_reset(MAP_CAMERICA, 1'b1);
		run_mix(16, 0, 0, 0, 1'b1);
		finish_test("reset");
		$display("summary: %0d tests ok, %0d tests bad, %0d assertion failures",
			tests_ok, tests_bad, u_discrete_mapper.u_chk.fail_cnt);
		if (!timed_out && tests_bad == 0 && u_discrete_mapper.u_chk.fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== nes_discrete_mapper.f ====
rtl/nes_bus_pkg.sv
rtl/mapper_pkg.sv
rtl/bank_regs.sv
rtl/prg_map.sv
rtl/chr_map.sv
rtl/discrete_mapper.sv
verif/discrete_mapper_chk.sv
verif/map_scoreboard.sv
verif/tb_discrete_mapper.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the discrete mapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f nes_discrete_mapper.f --top-module tb_discrete_mapper \
	-Mdir obj_dir -o sim_discrete_mapper

# A failing run still leaves a complete log to search
./obj_dir/sim_discrete_mapper +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
	exit 0
fi
exit 1
